//--- all.f
source/riscv_isa_pkg.sv
source/decoder_pkg.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/hazard_unit.sv
source/decode_regs.sv
source/instr_decoder_top.sv
sim/tb_instr_decoder.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - files:
      - source/riscv_isa_pkg.sv
      - source/decoder_pkg.sv
      - source/imm_gen.sv
      - source/ctrl_decode.sv
      - source/hazard_unit.sv
      - source/decode_regs.sv
      - source/instr_decoder_top.sv
  - target: test
    files:
      - sim/tb_instr_decoder.sv

//--- sim/tb_instr_decoder.sv
// Testbench for the RV32I decode stage
// Table driven, each row drives one cycle, checks ready in that cycle
// and the registered fields after the following clock edge

`timescale 1ns/100ps

module tb_instr_decoder;

    import riscv_isa_pkg::*;
    import decoder_pkg::*;

    localparam int MAX_ROWS      = 32;
    localparam int READY_TIMEOUT = 20;

    logic      clk_i;
    logic      rstn_i;
    instr_t    instr_i;
    logic      instr_valid_i;
    logic      ready_o;
    logic      illegal_instr_o;
    alu_sel_t  alu_sel_o;
    logic      alu_wb_o;
    reg_addr_t alu_dest_o;
    reg_addr_t rf_addr_a_o;
    reg_addr_t rf_addr_b_o;
    logic      is_imm_o;
    data_t     imm_o;
    logic      lsu_new_o;
    lsu_ctrl_t lsu_ctrl_o;
    reg_addr_t lsu_regdest_o;

    // Stimulus and expected values, one entry per cycle
    string     t_name  [MAX_ROWS];
    instr_t    t_instr [MAX_ROWS];
    logic      t_valid [MAX_ROWS];
    logic      t_ready [MAX_ROWS];
    logic      t_ill   [MAX_ROWS];
    alu_sel_t  t_alu   [MAX_ROWS];
    logic      t_wb    [MAX_ROWS];
    reg_addr_t t_dest  [MAX_ROWS];
    reg_addr_t t_ra    [MAX_ROWS];
    reg_addr_t t_rb    [MAX_ROWS];
    logic      t_isimm [MAX_ROWS];
    data_t     t_imm   [MAX_ROWS];
    logic      t_lsu   [MAX_ROWS];
    lsu_ctrl_t t_lctl  [MAX_ROWS];
    reg_addr_t t_ldest [MAX_ROWS];
    int        n_rows;

    instr_decoder_top u_instr_decoder_top (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .instr_i         (instr_i),
        .instr_valid_i   (instr_valid_i),
        .ready_o         (ready_o),
        .illegal_instr_o (illegal_instr_o),
        .alu_sel_o       (alu_sel_o),
        .alu_wb_o        (alu_wb_o),
        .alu_dest_o      (alu_dest_o),
        .rf_addr_a_o     (rf_addr_a_o),
        .rf_addr_b_o     (rf_addr_b_o),
        .is_imm_o        (is_imm_o),
        .imm_o           (imm_o),
        .lsu_new_o       (lsu_new_o),
        .lsu_ctrl_o      (lsu_ctrl_o),
        .lsu_regdest_o   (lsu_regdest_o)
    );

    always #4 clk_i = ~clk_i;  // 8 ns period

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic data_check(input string name, input string field,
                              input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", name, field, exp, act);
            $display("Simulation failed");
            $fatal(1, "Decoder output mismatch");
        end
    endtask

    task automatic reg_check(input string name, input string field,
                             input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %0d actual %0d", name, field, exp, act);
            $display("Simulation failed");
            $fatal(1, "Decoder output mismatch");
        end
    endtask

    task automatic alu_check(input string name, input alu_sel_t exp, input alu_sel_t act);
        if (act !== exp) begin
            $display("** Error: %s alu_sel_o expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Decoder output mismatch");
        end
    endtask

    task automatic lsu_check(input string name, input lsu_ctrl_t exp, input lsu_ctrl_t act);
        if (act !== exp) begin
            $display("** Error: %s lsu_ctrl_o expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Decoder output mismatch");
        end
    endtask

    task automatic bit_check(input string name, input string field,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %b actual %b", name, field, exp, act);
            $display("Simulation failed");
            $fatal(1, "Decoder output mismatch");
        end
    endtask

    // All eleven registered outputs in one go
    task automatic outputs_check(input string name, input logic ill, input alu_sel_t alu,
                                 input logic wb, input reg_addr_t dest, input reg_addr_t ra,
                                 input reg_addr_t rb, input logic isimm, input data_t imm,
                                 input logic lsu, input lsu_ctrl_t lctl,
                                 input reg_addr_t ldest);
        bit_check(name, "illegal_instr_o", ill, illegal_instr_o);
        alu_check(name, alu, alu_sel_o);
        bit_check(name, "alu_wb_o", wb, alu_wb_o);
        reg_check(name, "alu_dest_o", dest, alu_dest_o);
        reg_check(name, "rf_addr_a_o", ra, rf_addr_a_o);
        reg_check(name, "rf_addr_b_o", rb, rf_addr_b_o);
        bit_check(name, "is_imm_o", isimm, is_imm_o);
        data_check(name, "imm_o", imm, imm_o);
        bit_check(name, "lsu_new_o", lsu, lsu_new_o);
        lsu_check(name, lctl, lsu_ctrl_o);
        reg_check(name, "lsu_regdest_o", ldest, lsu_regdest_o);
    endtask

    //////////////////////////////
    // Table and sequencing
    //////////////////////////////
    task automatic add_row(input string name, input instr_t instr, input logic valid,
                           input logic ready, input logic ill, input alu_sel_t alu,
                           input logic wb, input reg_addr_t dest, input reg_addr_t ra,
                           input reg_addr_t rb, input logic isimm, input data_t imm,
                           input logic lsu, input lsu_ctrl_t lctl, input reg_addr_t ldest);
        t_name[n_rows]  = name;
        t_instr[n_rows] = instr;
        t_valid[n_rows] = valid;
        t_ready[n_rows] = ready;
        t_ill[n_rows]   = ill;
        t_alu[n_rows]   = alu;
        t_wb[n_rows]    = wb;
        t_dest[n_rows]  = dest;
        t_ra[n_rows]    = ra;
        t_rb[n_rows]    = rb;
        t_isimm[n_rows] = isimm;
        t_imm[n_rows]   = imm;
        t_lsu[n_rows]   = lsu;
        t_lctl[n_rows]  = lctl;
        t_ldest[n_rows] = ldest;
        n_rows++;
    endtask

    task automatic apply_reset();
        rstn_i        = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (ready_o !== 1'b1) begin
            if (cycles == READY_TIMEOUT) begin
                $display("Timeout: ready_o never went high after reset");
                $display("Simulation failed");
                $fatal(1, "Ready timeout");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
    endtask

    initial begin
        clk_i  = 1'b0;
        n_rows = 0;
        //       name         instr         v  rdy ill alu  wb dst ra rb imm? imm
        //       lsu lctl ldest
        add_row("addi_neg",  32'hFFB00293, 1, 1, 0, 4'h0, 1, 5, 0, 0, 1, 32'hFFFFFFFB, 0, 4'h0, 0);
        add_row("add_stall", 32'h00128333, 1, 0, 0, 4'h0, 0, 6, 5, 1, 0, 32'h00000000, 0, 4'h0, 0);
        // Retry is taken in DEC_STALL, where ready is still low
        add_row("add_retry", 32'h00128333, 1, 0, 0, 4'h0, 1, 6, 5, 1, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("sub",       32'h403103B3, 1, 1, 0, 4'h8, 1, 7, 2, 3, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("addi_x0",   32'h00100013, 1, 1, 0, 4'h0, 1, 0, 0, 0, 1, 32'h00000001, 0, 4'h0, 0);
        add_row("read_x0",   32'h00000433, 1, 1, 0, 4'h0, 1, 8, 0, 0, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("srai",      32'h40355493, 1, 1, 0, 4'hD, 1, 9, 10, 0, 1, 32'h00000403, 0, 4'h0, 0);
        add_row("lw_neg",    32'hFF812583, 1, 1, 0, 4'h0, 0, 0, 2, 0, 1, 32'hFFFFFFF8, 1, 4'h2, 11);
        add_row("sw_neg",    32'hFE41A623, 1, 1, 0, 4'h0, 0, 0, 3, 4, 1, 32'hFFFFFFEC, 1, 4'hA, 0);
        // Reads x12, which the store above only holds as immediate bits
        add_row("st_reader", 32'h00460633, 1, 1, 0, 4'h0, 1, 12, 12, 4, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("beq_neg",   32'hFE2088E3, 1, 1, 0, 4'h0, 0, 0, 1, 2, 1, 32'hFFFFFFF0, 0, 4'h0, 0);
        add_row("jal_pos",   32'h001000EF, 1, 1, 0, 4'h0, 1, 1, 0, 0, 1, 32'h00000800, 0, 4'h0, 0);
        add_row("lui_neg",   32'hFFFFF137, 1, 1, 0, 4'h0, 1, 2, 0, 0, 1, 32'hFFFFF000, 0, 4'h0, 0);
        add_row("idle",      32'h00000000, 0, 1, 0, 4'h0, 1, 2, 0, 0, 1, 32'hFFFFF000, 0, 4'h0, 0);
        add_row("fence",     32'h0000000F, 1, 1, 1, 4'h0, 0, 0, 0, 0, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("locked",    32'hFFB00293, 1, 0, 1, 4'h0, 0, 0, 0, 0, 0, 32'h00000000, 0, 4'h0, 0);
        add_row("lock_idle", 32'h00000000, 0, 0, 1, 4'h0, 0, 0, 0, 0, 0, 32'h00000000, 0, 4'h0, 0);

        apply_reset();
        wait_for_ready();
        outputs_check("reset", 0, 4'h0, 0, 0, 0, 0, 0, 32'h0, 0, 4'h0, 0);

        for (int i = 0; i < n_rows; i++) begin
            instr_i       = t_instr[i];
            instr_valid_i = t_valid[i];
            #1;
            bit_check(t_name[i], "ready_o", t_ready[i], ready_o);
            @(posedge clk_i);
            #1;
            outputs_check(t_name[i], t_ill[i], t_alu[i], t_wb[i], t_dest[i], t_ra[i],
                          t_rb[i], t_isimm[i], t_imm[i], t_lsu[i], t_lctl[i], t_ldest[i]);
        end

        // Only a reset clears the error lock
        apply_reset();
        wait_for_ready();
        outputs_check("reset_after_error", 0, 4'h0, 0, 0, 0, 0, 0, 32'h0, 0, 4'h0, 0);

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- source/instr_decoder_top.sv
// RV32I decode stage top level
// Combinational field, immediate and hazard decode feeding one
// register stage, with a combinational ready back to fetch

`timescale 1ns/100ps

module instr_decoder_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  riscv_isa_pkg::instr_t    instr_i,
    input  logic                     instr_valid_i,
    output logic                     ready_o,
    output logic                     illegal_instr_o,
    output decoder_pkg::alu_sel_t    alu_sel_o,
    output logic                     alu_wb_o,
    output riscv_isa_pkg::reg_addr_t alu_dest_o,
    output riscv_isa_pkg::reg_addr_t rf_addr_a_o,
    output riscv_isa_pkg::reg_addr_t rf_addr_b_o,
    output logic                     is_imm_o,
    output riscv_isa_pkg::data_t     imm_o,
    output logic                     lsu_new_o,
    output decoder_pkg::lsu_ctrl_t   lsu_ctrl_o,
    output riscv_isa_pkg::reg_addr_t lsu_regdest_o
);

    import riscv_isa_pkg::*;
    import decoder_pkg::*;

    data_t     imm;
    alu_sel_t  alu_sel;
    lsu_ctrl_t lsu_ctrl;
    reg_addr_t alu_dest, rs1_addr, rs2_addr, rd_addr, lsu_regdest;
    logic      alu_wb, is_imm, lsu_new, illegal;
    logic      rs1_used, rs2_used, rd_written;
    logic      stall, accept;

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm)
    );

    ctrl_decode u_ctrl_decode (
        .instr_i       (instr_i),
        .alu_sel_o     (alu_sel),
        .alu_wb_o      (alu_wb),
        .alu_dest_o    (alu_dest),
        .is_imm_o      (is_imm),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_used_o    (rs1_used),
        .rs2_used_o    (rs2_used),
        .rd_written_o  (rd_written),
        .rd_addr_o     (rd_addr),
        .lsu_new_o     (lsu_new),
        .lsu_ctrl_o    (lsu_ctrl),
        .lsu_regdest_o (lsu_regdest),
        .illegal_o     (illegal)
    );

    hazard_unit u_hazard_unit (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .illegal_i     (illegal),
        .rs1_used_i    (rs1_used),
        .rs2_used_i    (rs2_used),
        .rd_written_i  (rd_written),
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .rd_addr_i     (rd_addr),
        .stall_o       (stall),
        .accept_o      (accept),
        .ready_o       (ready_o)
    );

    decode_regs u_decode_regs (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .accept_i        (accept),
        .stall_i         (stall),
        .illegal_i       (illegal),
        .alu_sel_i       (alu_sel),
        .alu_wb_i        (alu_wb),
        .alu_dest_i      (alu_dest),
        .rs1_addr_i      (rs1_addr),
        .rs2_addr_i      (rs2_addr),
        .is_imm_i        (is_imm),
        .imm_i           (imm),
        .lsu_new_i       (lsu_new),
        .lsu_ctrl_i      (lsu_ctrl),
        .lsu_regdest_i   (lsu_regdest),
        .illegal_instr_o (illegal_instr_o),
        .alu_sel_o       (alu_sel_o),
        .alu_wb_o        (alu_wb_o),
        .alu_dest_o      (alu_dest_o),
        .rf_addr_a_o     (rf_addr_a_o),
        .rf_addr_b_o     (rf_addr_b_o),
        .is_imm_o        (is_imm_o),
        .imm_o           (imm_o),
        .lsu_new_o       (lsu_new_o),
        .lsu_ctrl_o      (lsu_ctrl_o),
        .lsu_regdest_o   (lsu_regdest_o)
    );

endmodule

//--- source/decode_regs.sv
// Decode output stage
// Registers the decoded fields when an instruction is accepted and
// turns a stalled instruction into a bubble

`timescale 1ns/100ps

module decode_regs (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     accept_i,
    input  logic                     stall_i,
    input  logic                     illegal_i,
    input  decoder_pkg::alu_sel_t    alu_sel_i,
    input  logic                     alu_wb_i,
    input  riscv_isa_pkg::reg_addr_t alu_dest_i,
    input  riscv_isa_pkg::reg_addr_t rs1_addr_i,
    input  riscv_isa_pkg::reg_addr_t rs2_addr_i,
    input  logic                     is_imm_i,
    input  riscv_isa_pkg::data_t     imm_i,
    input  logic                     lsu_new_i,
    input  decoder_pkg::lsu_ctrl_t   lsu_ctrl_i,
    input  riscv_isa_pkg::reg_addr_t lsu_regdest_i,
    output logic                     illegal_instr_o,
    output decoder_pkg::alu_sel_t    alu_sel_o,
    output logic                     alu_wb_o,
    output riscv_isa_pkg::reg_addr_t alu_dest_o,
    output riscv_isa_pkg::reg_addr_t rf_addr_a_o,
    output riscv_isa_pkg::reg_addr_t rf_addr_b_o,
    output logic                     is_imm_o,
    output riscv_isa_pkg::data_t     imm_o,
    output logic                     lsu_new_o,
    output decoder_pkg::lsu_ctrl_t   lsu_ctrl_o,
    output riscv_isa_pkg::reg_addr_t lsu_regdest_o
);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            illegal_instr_o <= 1'b0;
            alu_sel_o       <= '0;
            alu_wb_o        <= 1'b0;
            alu_dest_o      <= '0;
            rf_addr_a_o     <= '0;
            rf_addr_b_o     <= '0;
            is_imm_o        <= 1'b0;
            imm_o           <= '0;
            lsu_new_o       <= 1'b0;
            lsu_ctrl_o      <= '0;
            lsu_regdest_o   <= '0;
        end else if (accept_i) begin
            // Side effects masked on a stall, the rest passes through
            illegal_instr_o <= illegal_i & ~stall_i;
            alu_wb_o        <= alu_wb_i & ~stall_i;
            lsu_new_o       <= lsu_new_i & ~stall_i;
            alu_sel_o       <= alu_sel_i;
            alu_dest_o      <= alu_dest_i;
            rf_addr_a_o     <= rs1_addr_i;
            rf_addr_b_o     <= rs2_addr_i;
            is_imm_o        <= is_imm_i;
            imm_o           <= imm_i;
            lsu_ctrl_o      <= lsu_ctrl_i;
            lsu_regdest_o   <= lsu_regdest_i;
        end
    end

endmodule

//--- source/hazard_unit.sv
// Hazard unit
// Tracks the last issued destination register and the decoder state,
// detects read-after-write conflicts and drives the fetch ready

`timescale 1ns/100ps

module hazard_unit (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     instr_valid_i,
    input  logic                     illegal_i,
    input  logic                     rs1_used_i,
    input  logic                     rs2_used_i,
    input  logic                     rd_written_i,
    input  riscv_isa_pkg::reg_addr_t rs1_addr_i,
    input  riscv_isa_pkg::reg_addr_t rs2_addr_i,
    input  riscv_isa_pkg::reg_addr_t rd_addr_i,
    output logic                     stall_o,
    output logic                     accept_o,
    output logic                     ready_o
);

    import riscv_isa_pkg::*;
    import decoder_pkg::*;

    dec_state_e state;
    reg_addr_t  prev_dest;
    logic       rs1_hit;
    logic       rs2_hit;

    //////////////////////////////
    // RAW detection
    //////////////////////////////
    assign rs1_hit = rs1_used_i && (rs1_addr_i != '0) && (rs1_addr_i == prev_dest);
    assign rs2_hit = rs2_used_i && (rs2_addr_i != '0) && (rs2_addr_i == prev_dest);

    assign stall_o  = instr_valid_i && (state == DEC_OK) && (rs1_hit || rs2_hit);
    assign accept_o = instr_valid_i && (state != DEC_ERROR);
    assign ready_o  = (state == DEC_OK) && !stall_o;  // Straight back to fetch

    // Only an instruction that really issued can create a hazard
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            prev_dest <= '0;
        end else if (accept_o && !stall_o && rd_written_i) begin
            prev_dest <= rd_addr_i;
        end else begin
            prev_dest <= '0;
        end
    end

    //////////////////////////////
    // State machine
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state <= DEC_OK;
        end else begin
            case (state)
                DEC_OK: begin
                    if (instr_valid_i && illegal_i) state <= DEC_ERROR;
                    else if (stall_o)               state <= DEC_STALL;
                end
                DEC_STALL: begin
                    if (instr_valid_i && illegal_i) state <= DEC_ERROR;
                    else                            state <= DEC_OK;  // One bubble only
                end
                default: state <= DEC_ERROR;  // Locked until reset
            endcase
        end
    end

endmodule

//--- source/ctrl_decode.sv
// Control decoder
// Maps the opcode class onto ALU, register file and LSU control,
// flags the illegal opcodes and reports which registers are touched

`timescale 1ns/100ps

module ctrl_decode (
    input  riscv_isa_pkg::instr_t    instr_i,
    output decoder_pkg::alu_sel_t    alu_sel_o,
    output logic                     alu_wb_o,
    output riscv_isa_pkg::reg_addr_t alu_dest_o,
    output logic                     is_imm_o,
    output riscv_isa_pkg::reg_addr_t rs1_addr_o,
    output riscv_isa_pkg::reg_addr_t rs2_addr_o,
    output logic                     rs1_used_o,
    output logic                     rs2_used_o,
    output logic                     rd_written_o,
    output riscv_isa_pkg::reg_addr_t rd_addr_o,
    output logic                     lsu_new_o,
    output decoder_pkg::lsu_ctrl_t   lsu_ctrl_o,
    output riscv_isa_pkg::reg_addr_t lsu_regdest_o,
    output logic                     illegal_o
);

    import riscv_isa_pkg::*;
    import decoder_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      alt;  // Instruction bit 30

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[FUNCT3_LSB +: 3];
    assign rd     = instr_i[RD_LSB +: REG_ADDR_W];
    assign rs1    = instr_i[RS1_LSB +: REG_ADDR_W];
    assign rs2    = instr_i[RS2_LSB +: REG_ADDR_W];
    assign alt    = instr_i[ALT_BIT];

    //////////////////////////////
    // Per class control
    //////////////////////////////
    always_comb begin
        rs1_used_o    = 1'b0;
        rs2_used_o    = 1'b0;
        rd_written_o  = 1'b0;
        is_imm_o      = 1'b1;  // Every legal class but OP
        alu_sel_o     = ALU_SEL_ADD;
        lsu_new_o     = 1'b0;
        lsu_ctrl_o    = LSU_CTRL_NONE;
        lsu_regdest_o = '0;
        illegal_o     = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                rd_written_o = 1'b1;
            end
            OPC_JALR: begin
                rs1_used_o   = 1'b1;
                rd_written_o = 1'b1;
            end
            OPC_OPIMM: begin
                rs1_used_o   = 1'b1;
                rd_written_o = 1'b1;
                // Bit 30 is part of the immediate except for shift right
                alu_sel_o    = {(funct3 == FUNCT3_SR) & alt, funct3};
            end
            OPC_OP: begin
                rs1_used_o   = 1'b1;
                rs2_used_o   = 1'b1;
                rd_written_o = 1'b1;
                is_imm_o     = 1'b0;
                alu_sel_o    = {alt, funct3};
            end
            OPC_LOAD: begin
                rs1_used_o    = 1'b1;
                rd_written_o  = 1'b1;
                lsu_new_o     = 1'b1;
                lsu_ctrl_o    = {1'b0, funct3};
                lsu_regdest_o = rd;  // Written back by the LSU, not the ALU
            end
            OPC_STORE: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                lsu_new_o  = 1'b1;
                lsu_ctrl_o = {1'b1, funct3};
            end
            OPC_BRANCH: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
            end
            default: begin
                is_imm_o  = 1'b0;
                illegal_o = 1'b1;
            end
        endcase
    end

    // ALU owns the writeback for everything except loads
    assign alu_wb_o   = rd_written_o & (opcode != OPC_LOAD);
    assign alu_dest_o = alu_wb_o ? rd : '0;

    // Unused fields read as x0 so the hazard check ignores them
    assign rs1_addr_o = rs1_used_o ? rs1 : '0;
    assign rs2_addr_o = rs2_used_o ? rs2 : '0;
    assign rd_addr_o  = rd_written_o ? rd : '0;

endmodule

//--- source/imm_gen.sv
// Immediate generator
// Picks the immediate format from the opcode, reassembles the
// scattered bit fields and sign-extends the result to XLEN

`timescale 1ns/100ps

module imm_gen (
    input  riscv_isa_pkg::instr_t instr_i,
    output riscv_isa_pkg::data_t  imm_o
);

    import riscv_isa_pkg::*;

    opcode_t opcode;
    data_t   imm_i_fmt;
    data_t   imm_s_fmt;
    data_t   imm_b_fmt;
    data_t   imm_j_fmt;
    data_t   imm_u_fmt;

    assign opcode = instr_i[6:0];

    //////////////////////////////
    // Format assembly
    //////////////////////////////
    assign imm_i_fmt = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    // Bit 0 is implied zero for branch and jump targets
    assign imm_b_fmt = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_fmt = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    assign imm_u_fmt = {instr_i[31:12], 12'b0};  // Upper 20 bits, no extension

    //////////////////////////////
    // Format select
    //////////////////////////////
    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OPIMM, OPC_JALR: imm_o = imm_i_fmt;
            OPC_STORE:                     imm_o = imm_s_fmt;
            OPC_BRANCH:                    imm_o = imm_b_fmt;
            OPC_JAL:                       imm_o = imm_j_fmt;
            OPC_LUI, OPC_AUIPC:            imm_o = imm_u_fmt;
            default:                       imm_o = '0;  // OP and unknown opcodes
        endcase
    end

endmodule

//--- source/decoder_pkg.sv
// Decoder control definitions
// ALU and LSU command encodings and the decoder state machine

package decoder_pkg;

    //////////////////////////////
    // Control words
    //////////////////////////////
    localparam int ALU_SEL_W  = 4;
    localparam int LSU_CTRL_W = 4;

    // {instr[30], funct3}
    typedef logic [ALU_SEL_W-1:0] alu_sel_t;

    // {store flag, funct3}
    typedef logic [LSU_CTRL_W-1:0] lsu_ctrl_t;

    localparam alu_sel_t  ALU_SEL_ADD   = 4'b0000;  // Default for non ALU classes
    localparam lsu_ctrl_t LSU_CTRL_NONE = 4'b0000;

    //////////////////////////////
    // Decoder state
    //////////////////////////////
    typedef enum logic [2:0] {
        DEC_OK    = 3'b001,
        DEC_STALL = 3'b010,  // One bubble inserted, retry follows
        DEC_ERROR = 3'b100   // Sticky until reset
    } dec_state_e;

endpackage

//--- source/riscv_isa_pkg.sv
// RV32I instruction set definitions
// Word and field types, major opcodes and instruction field positions
// shared by the decoder blocks and the testbench

package riscv_isa_pkg;

    //////////////////////////////
    // Widths and types
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       instr_t;     // Raw instruction word
    typedef logic [XLEN-1:0]       data_t;      // Data word, carries the immediate
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // x0 .. x31
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    //////////////////////////////
    // Field positions
    //////////////////////////////
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int ALT_BIT    = 30;  // SUB / SRA variant select

    //////////////////////////////
    // Major opcodes
    //////////////////////////////
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // SRLI / SRAI share this funct3, bit 30 tells them apart
    localparam funct3_t FUNCT3_SR = 3'b101;

endpackage
